//--- latency_probe.f
rtl/latency_pkg.sv
rtl/stream_if.sv
rtl/probe_regs.sv
rtl/sample_delay_line.sv
rtl/marker_timer.sv
rtl/latency_probe_top.sv
test/latency_probe_sva.sv
test/latency_probe_tb.sv

//--- Makefile
# Verilator build and run for the latency probe testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
	  --top-module latency_probe_tb -f latency_probe.f

run: compile
	./obj_dir/Vlatency_probe_tb 2>&1 | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/latency_probe_tb.sv
// Cycle-based model updated on rising edges; outputs compared on falling edges, first error fatal
module latency_probe_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import latency_pkg::*;

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 3;
  localparam int unsigned RAND_SEED    = 32'h0d18_f95f;
  // Phase lengths in cycles
  localparam int N_REG   = 200;
  localparam int N_PASS  = 600;
  localparam int N_BP    = 1200;
  localparam int N_DRAIN = DEPTH + 4;
  localparam int N_TOTAL = RESET_CYCLES + N_REG + N_PASS + N_BP + N_DRAIN;
  localparam int WATCHDOG_NS = N_TOTAL * CLK_PERIOD + 500;
  // Stimulus modes
  localparam int MODE_IDLE  = 0;
  localparam int MODE_PASS  = 1;
  localparam int MODE_BP    = 2;
  localparam int MODE_DRAIN = 3;

  logic              ce_clk;
  logic              reset;
  logic [DATA_W-1:0] i_tdata;
  logic              i_tlast;
  logic              i_tvalid;
  logic              i_tready;
  logic [DATA_W-1:0] o_tdata;
  logic              o_tlast;
  logic              o_tvalid;
  logic              o_tready;
  logic [HDR_W-1:0]  o_tuser;
  logic              i_set_stb;
  logic [ADDR_W-1:0] i_set_addr;
  logic [REG_W-1:0]  i_set_data;
  logic [ADDR_W-1:0] i_rb_addr;
  logic [DATA_W-1:0] o_rb_data;

  // Reference model state
  logic [DATA_W-1:0] m_cnt;
  logic [HALF_W-1:0] m_stamp;
  logic [REG_W-1:0]  m_ids;
  logic [REG_W-1:0]  m_scratch;
  logic [DATA_W-1:0] m_rb;
  logic [HDR_W-1:0]  m_hdr;
  // Beats in flight, oldest first, age in advancing edges
  logic [DATA_W-1:0] q_data [$];
  logic              q_last [$];
  int                q_age  [$];
  int                beats_in;
  int                beats_seen;

  latency_probe_top latency_probe_top_inst (
    .ce_clk     (ce_clk),
    .reset      (reset),
    .i_tdata    (i_tdata),
    .i_tlast    (i_tlast),
    .i_tvalid   (i_tvalid),
    .i_tready   (i_tready),
    .o_tdata    (o_tdata),
    .o_tlast    (o_tlast),
    .o_tvalid   (o_tvalid),
    .o_tready   (o_tready),
    .o_tuser    (o_tuser),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_rb_addr  (i_rb_addr),
    .o_rb_data  (o_rb_data)
  );

  always #(CLK_PERIOD / 2) ce_clk = ~ce_clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [HDR_W-1:0] got,
                             input logic [HDR_W-1:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
      $display("FAIL: see errors above");
      $fatal(1, "output check failed");
    end
  endtask

  // User registers, or anything else on the bus
  function automatic logic [ADDR_W-1:0] pick_set_addr();
    case ($urandom_range(2))
      0:       return SR_STREAM_IDS;
      1:       return SR_SCRATCH;
      default: return ADDR_W'($urandom);
    endcase
  endfunction

  function automatic logic [ADDR_W-1:0] pick_rb_addr();
    case ($urandom_range(2))
      0:       return RB_STREAM_IDS;
      1:       return RB_SCRATCH;
      default: return ADDR_W'($urandom);
    endcase
  endfunction

  // Roughly one word in eight is the marker
  function automatic logic [DATA_W-1:0] random_word();
    if (($urandom % 8) == 0) begin
      return MARKER;
    end
    return {$urandom, $urandom};
  endfunction

  task automatic drive_cycle(input int mode);
    @(posedge ce_clk);
    #1;
    i_set_stb  = ($urandom % 2) == 0;
    i_set_addr = pick_set_addr();
    i_set_data = $urandom;
    i_rb_addr  = pick_rb_addr();
    i_tdata    = random_word();
    i_tlast    = ($urandom % 4) == 0;
    case (mode)
      MODE_IDLE: begin
        i_tvalid = 1'b0;
        o_tready = ($urandom % 2) == 0;
      end
      MODE_PASS: begin
        i_tvalid = ($urandom % 2) == 0;
        o_tready = 1'b1;
      end
      MODE_BP: begin
        i_tvalid = ($urandom % 4) != 0;
        o_tready = ($urandom % 2) == 0;
      end
      default: begin
        i_tvalid = 1'b0;
        o_tready = 1'b1;
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model, all terms taken from values before the edge
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge ce_clk or negedge reset) begin : model_update
    logic [DATA_W-1:0] cnt_old;
    logic [REG_W-1:0]  ids_old;
    if (!reset) begin
      m_cnt     = '0;
      m_stamp   = '0;
      m_ids     = '0;
      m_scratch = '0;
      m_rb      = '0;
      m_hdr     = '0;
      q_data.delete();
      q_last.delete();
      q_age.delete();
    end else begin
      cnt_old = m_cnt;
      ids_old = m_ids;
      // Readback sees the registers before any write on this edge
      if (i_rb_addr == RB_STREAM_IDS) m_rb = DATA_W'(m_ids);
      else if (i_rb_addr == RB_SCRATCH) m_rb = DATA_W'(m_scratch);
      else m_rb = RB_FILLER;
      if (i_set_stb && i_set_addr == SR_STREAM_IDS) m_ids = i_set_data;
      if (i_set_stb && i_set_addr == SR_SCRATCH) m_scratch = i_set_data;
      // Flags, source ID, destination ID, count one cycle old
      m_hdr = {HDR_FLAGS, ids_old[REG_W-1 -: SID_W], ids_old[SID_W-1:0], cnt_old};
      if (i_tvalid && o_tready && i_tdata == MARKER) m_cnt = '0;
      else m_cnt = cnt_old + 64'd1;
      if (o_tready) begin
        // Oldest beat at full age leaves now
        if (q_age.size() > 0 && q_age[0] == DEPTH) begin
          if (q_data[0] == MARKER) m_stamp = cnt_old[HALF_W-1:0];
          void'(q_data.pop_front());
          void'(q_last.pop_front());
          void'(q_age.pop_front());
        end
        foreach (q_age[i]) q_age[i]++;
        if (i_tvalid) begin
          q_data.push_back(i_tdata);
          q_last.push_back(i_tlast);
          q_age.push_back(1);
          beats_in++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output checks on the falling edge
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge ce_clk) begin : output_check
    logic              head_valid;
    logic [DATA_W-1:0] exp_data;
    if (reset) begin
      head_valid = q_age.size() > 0 && q_age[0] == DEPTH;
      check_value("i_tready", HDR_W'(i_tready), HDR_W'(o_tready));
      check_value("o_tvalid", HDR_W'(o_tvalid), HDR_W'(head_valid));
      if (head_valid) begin
        // Marker shows elapsed count over previous exit stamp
        exp_data = (q_data[0] == MARKER) ? {m_cnt[HALF_W-1:0], m_stamp} : q_data[0];
        check_value("o_tdata", HDR_W'(o_tdata), HDR_W'(exp_data));
        check_value("o_tlast", HDR_W'(o_tlast), HDR_W'(q_last[0]));
      end
      check_value("o_tuser", o_tuser, m_hdr);
      check_value("o_rb_data", HDR_W'(o_rb_data), HDR_W'(m_rb));
      if (o_tvalid && o_tready) beats_seen++;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired before the stimulus finished");
    $display("FAIL: see errors above");
    $fatal(1, "watchdog timeout");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    ce_clk     = 1'b0;
    reset      = 1'b0;
    i_tdata    = '0;
    i_tlast    = 1'b0;
    i_tvalid   = 1'b0;
    o_tready   = 1'b0;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_rb_addr  = '0;
    beats_in   = 0;
    beats_seen = 0;
    void'($urandom(RAND_SEED));
    repeat (RESET_CYCLES) @(posedge ce_clk);
    #1;
    reset = 1'b1;
    // Registers only, stream idle
    repeat (N_REG) drive_cycle(MODE_IDLE);
    // Ready held high, bubbles on the input
    repeat (N_PASS) drive_cycle(MODE_PASS);
    // Random back-pressure
    repeat (N_BP) drive_cycle(MODE_BP);
    // Flush everything still in flight
    repeat (N_DRAIN) drive_cycle(MODE_DRAIN);
    @(negedge ce_clk);
    if (beats_in == beats_seen && q_age.size() == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("MISMATCH beat count: in %h out %h left %h", beats_in, beats_seen,
               q_age.size());
      $display("FAIL: see errors above");
      $fatal(1, "beat sequence incomplete");
    end
  end

endmodule

//--- test/latency_probe_sva.sv
// Checks handshake and hold rules at the top-level ports only; internal stages are not observed
module latency_probe_sva (
  input logic ce_clk,
  input logic reset,
  input logic i_tready,
  input logic o_tready,
  input logic o_tvalid,
  input logic o_tlast
);
  timeunit 1ns;
  timeprecision 100ps;

  // Ready passes straight back upstream
  a_ready_through: assert property (@(posedge ce_clk) i_tready == o_tready)
    else $error("i_tready differs from o_tready");

  // First cycle out of reset is still empty
  a_after_reset: assert property (@(posedge ce_clk) $rose(reset) |-> !o_tvalid)
    else $error("o_tvalid high in the cycle after reset");

  // Stalled line keeps its tail slot
  a_hold_stall: assert property (@(posedge ce_clk) disable iff (!reset)
    !o_tready |=> $stable(o_tvalid) && $stable(o_tlast))
    else $error("output valid or last changed while o_tready was low");

endmodule

bind latency_probe_top latency_probe_sva latency_probe_sva_inst (
  .ce_clk   (ce_clk),
  .reset    (reset),
  .i_tready (i_tready),
  .o_tready (o_tready),
  .o_tvalid (o_tvalid),
  .o_tlast  (o_tlast)
);

//--- rtl/latency_probe_top.sv
// Single clock domain; i_tready follows o_tready combinationally and outputs lag inputs by DEPTH
module latency_probe_top (
  input  logic                           ce_clk,
  input  logic                           reset,
  // Upstream stream
  input  logic [latency_pkg::DATA_W-1:0] i_tdata,
  input  logic                           i_tlast,
  input  logic                           i_tvalid,
  output logic                           i_tready,
  // Downstream stream, o_tready comes from the sink
  output logic [latency_pkg::DATA_W-1:0] o_tdata,
  output logic                           o_tlast,
  output logic                           o_tvalid,
  input  logic                           o_tready,
  output logic [latency_pkg::HDR_W-1:0]  o_tuser,
  // Settings bus and readback
  input  logic                           i_set_stb,
  input  logic [latency_pkg::ADDR_W-1:0] i_set_addr,
  input  logic [latency_pkg::REG_W-1:0]  i_set_data,
  input  logic [latency_pkg::ADDR_W-1:0] i_rb_addr,
  output logic [latency_pkg::DATA_W-1:0] o_rb_data
);
  import latency_pkg::*;

  logic [REG_W-1:0] stream_ids;

  ////////////////////////////////////////////////////////////////////////////
  // Streams between blocks
  ////////////////////////////////////////////////////////////////////////////
  stream_if ingress ();
  stream_if egress ();

  // Ingress fed from the top ports
  assign ingress.data  = i_tdata;
  assign ingress.last  = i_tlast;
  assign ingress.valid = i_tvalid;
  assign i_tready      = ingress.ready;

  // Settings and readback
  probe_regs probe_regs_inst (
    .ce_clk       (ce_clk),
    .reset        (reset),
    .i_set_stb    (i_set_stb),
    .i_set_addr   (i_set_addr),
    .i_set_data   (i_set_data),
    .i_rb_addr    (i_rb_addr),
    .o_rb_data    (o_rb_data),
    .o_stream_ids (stream_ids)
  );

  // Fixed four-stage delay
  sample_delay_line sample_delay_line_inst (
    .ce_clk (ce_clk),
    .reset  (reset),
    .s_in   (ingress.sink),
    .m_out  (egress.source)
  );

  // Timing, report substitution and header
  marker_timer marker_timer_inst (
    .ce_clk       (ce_clk),
    .reset        (reset),
    .s_ingress    (ingress.monitor),
    .s_egress     (egress.sink),
    .i_stream_ids (stream_ids),
    .o_tready     (o_tready),
    .o_tdata      (o_tdata),
    .o_tlast      (o_tlast),
    .o_tvalid     (o_tvalid),
    .o_tuser      (o_tuser)
  );

endmodule

//--- rtl/marker_timer.sv
// Counter wraps silently at 64 bits; the report carries only the low 32 bits of each count
module marker_timer (
  input  logic                           ce_clk,
  input  logic                           reset,
  stream_if.monitor                      s_ingress,
  stream_if.sink                         s_egress,
  input  logic [latency_pkg::REG_W-1:0]  i_stream_ids,
  input  logic                           o_tready,
  output logic [latency_pkg::DATA_W-1:0] o_tdata,
  output logic                           o_tlast,
  output logic                           o_tvalid,
  output logic [latency_pkg::HDR_W-1:0]  o_tuser
);
  import latency_pkg::*;

  logic [DATA_W-1:0] cnt_q;
  logic [HALF_W-1:0] stamp_q;
  logic [HDR_W-1:0]  hdr_q;
  logic [SID_W-1:0]  src_sid;
  logic [SID_W-1:0]  dst_sid;
  report_word_u      report;
  logic              marker_in;
  logic              marker_out;
  logic              marker_leave;

  ////////////////////////////////////////////////////////////////////////////
  // Marker detection at both ends
  ////////////////////////////////////////////////////////////////////////////
  // Accepted at the ingress
  assign marker_in = s_ingress.valid && s_ingress.ready && (s_ingress.data == MARKER);
  // Present at the egress, accepted or not
  assign marker_out   = s_egress.valid && (s_egress.data == MARKER);
  assign marker_leave = marker_out && o_tready;

  // Cycle counter, restarts on each marker entry
  always_ff @(posedge ce_clk or negedge reset) begin
    if (!reset) begin
      cnt_q <= '0;
    end else if (marker_in) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Egress stamp, count at the last marker exit
  always_ff @(posedge ce_clk or negedge reset) begin
    if (!reset) begin
      stamp_q <= '0;
    end else if (marker_leave) begin
      stamp_q <= cnt_q[HALF_W-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output word
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    report.fields.elapsed     = cnt_q[HALF_W-1:0];
    report.fields.prev_egress = stamp_q;
  end

  // Leaving marker shows the report instead
  assign o_tdata  = marker_out ? report.raw : s_egress.data;
  assign o_tlast  = s_egress.last;
  assign o_tvalid = s_egress.valid;
  assign s_egress.ready = o_tready;

  ////////////////////////////////////////////////////////////////////////////
  // Header register
  ////////////////////////////////////////////////////////////////////////////
  // Source ID high, destination ID low
  assign src_sid = i_stream_ids[REG_W-1 -: SID_W];
  assign dst_sid = i_stream_ids[SID_W-1:0];

  // Time field lags the counter by one cycle
  always_ff @(posedge ce_clk or negedge reset) begin
    if (!reset) begin
      hdr_q <= '0;
    end else begin
      hdr_q <= {HDR_FLAGS, src_sid, dst_sid, cnt_q};
    end
  end

  assign o_tuser = hdr_q;

endmodule

//--- rtl/sample_delay_line.sv
// Fixed latency of DEPTH advancing edges; bubbles ride in place so latency never varies
module sample_delay_line (
  input  logic     ce_clk,
  input  logic     reset,
  stream_if.sink   s_in,
  stream_if.source m_out
);
  import latency_pkg::*;

  // Stage storage, index 0 is nearest the input
  logic [DATA_W-1:0] data_q [DEPTH];
  logic [DEPTH-1:0]  last_q;
  logic [DEPTH-1:0]  valid_q;

  // Whole line moves as one
  logic advance;

  assign advance = m_out.ready;

  // Upstream sees downstream ready directly
  assign s_in.ready = m_out.ready;

  ////////////////////////////////////////////////////////////////////////////
  // Control bits per stage
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk or negedge reset) begin
    if (!reset) begin
      valid_q <= '0;
      last_q  <= '0;
    end else if (advance) begin
      // Shift toward the output, load head from input
      valid_q <= {valid_q[DEPTH-2:0], s_in.valid};
      last_q  <= {last_q[DEPTH-2:0], s_in.last};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload per stage
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (advance) begin
      data_q[0] <= s_in.data;
      for (int i = 1; i < DEPTH; i++) begin
        data_q[i] <= data_q[i-1];
      end
    end
  end

  // Tail stage drives the egress stream
  assign m_out.data  = data_q[DEPTH-1];
  assign m_out.last  = last_q[DEPTH-1];
  assign m_out.valid = valid_q[DEPTH-1];

endmodule

//--- rtl/probe_regs.sv
// Readback is always enabled and lags i_rb_addr by one cycle; writes land on i_set_stb only
module probe_regs (
  input  logic                       ce_clk,
  input  logic                       reset,
  input  logic                       i_set_stb,
  input  logic [latency_pkg::ADDR_W-1:0] i_set_addr,
  input  logic [latency_pkg::REG_W-1:0]  i_set_data,
  input  logic [latency_pkg::ADDR_W-1:0] i_rb_addr,
  output logic [latency_pkg::DATA_W-1:0] o_rb_data,
  output logic [latency_pkg::REG_W-1:0]  o_stream_ids
);
  import latency_pkg::*;

  // User register 0 and 1
  logic [REG_W-1:0]  stream_ids_q;
  logic [REG_W-1:0]  scratch_q;
  logic [DATA_W-1:0] rb_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Strobed writes
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk or negedge reset) begin
    if (!reset) begin
      stream_ids_q <= '0;
      scratch_q    <= '0;
    end else if (i_set_stb) begin
      // Other addresses belong to the shell, ignored here
      case (i_set_addr)
        SR_STREAM_IDS: stream_ids_q <= i_set_data;
        SR_SCRATCH:    scratch_q    <= i_set_data;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registered readback
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge ce_clk or negedge reset) begin
    if (!reset) begin
      rb_data_q <= '0;
    end else begin
      // Zero-extend 32-bit registers into the 64-bit port
      case (i_rb_addr)
        RB_STREAM_IDS: rb_data_q <= {{(DATA_W-REG_W){1'b0}}, stream_ids_q};
        RB_SCRATCH:    rb_data_q <= {{(DATA_W-REG_W){1'b0}}, scratch_q};
        default:       rb_data_q <= RB_FILLER;
      endcase
    end
  end

  assign o_rb_data    = rb_data_q;
  assign o_stream_ids = stream_ids_q;

endmodule

//--- rtl/stream_if.sv
// Plain valid/ready stream; a beat moves when valid and ready are both high, ready ignores valid
interface stream_if;
  import latency_pkg::*;

  // Payload
  logic [DATA_W-1:0] data;
  logic              last;
  // Handshake pair
  logic              valid;
  logic              ready;

  // Producer side
  modport source (
    output data, last, valid,
    input  ready
  );

  // Consumer side, owns ready
  modport sink (
    input  data, last, valid,
    output ready
  );

  // Observer only
  modport monitor (
    input data, last, valid, ready
  );

endinterface

//--- rtl/latency_pkg.sv
// Shared widths and constants; header layout assumes REG_W holds exactly two SID_W stream IDs
package latency_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Stream widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int DATA_W = 64;
  localparam int HALF_W = DATA_W / 2;
  // Delay line stages
  localparam int DEPTH  = 4;

  // Marker word that starts and ends a latency measurement
  localparam logic [DATA_W-1:0] MARKER = 64'h0000_0000_dead_beef;

  ////////////////////////////////////////////////////////////////////////////
  // Settings bus
  ////////////////////////////////////////////////////////////////////////////
  localparam int ADDR_W = 8;
  localparam int REG_W  = 32;

  // User space starts above the shell registers
  localparam logic [ADDR_W-1:0] SR_USER_BASE  = 8'd128;
  localparam logic [ADDR_W-1:0] SR_STREAM_IDS = SR_USER_BASE;
  localparam logic [ADDR_W-1:0] SR_SCRATCH    = SR_USER_BASE + 8'd1;

  // Readback map
  localparam logic [ADDR_W-1:0] RB_STREAM_IDS = 8'd0;
  localparam logic [ADDR_W-1:0] RB_SCRATCH    = 8'd1;
  localparam logic [DATA_W-1:0] RB_FILLER     = 64'h0BADC0DE0BADC0DE;

  ////////////////////////////////////////////////////////////////////////////
  // Header word
  ////////////////////////////////////////////////////////////////////////////
  localparam int HDR_W = 128;
  localparam int SID_W = 16;

  // Fixed flag fields, top of the header
  localparam logic [1:0]  HDR_TYPE     = 2'b00;
  localparam logic        HDR_HAS_TIME = 1'b1;
  localparam logic        HDR_EOB      = 1'b0;
  localparam logic [11:0] HDR_SEQNUM   = 12'h000;
  localparam logic [15:0] HDR_LEN      = 16'h0000;
  localparam logic [31:0] HDR_FLAGS    =
    {HDR_TYPE, HDR_HAS_TIME, HDR_EOB, HDR_SEQNUM, HDR_LEN};

  // Output word, either passed data or a marker report
  typedef struct packed {
    logic [HALF_W-1:0] elapsed;
    logic [HALF_W-1:0] prev_egress;
  } report_fields_t;

  typedef union packed {
    logic [DATA_W-1:0] raw;
    report_fields_t    fields;
  } report_word_u;

endpackage
